// File: source/umi_pkg.sv
// UMI command package: width, opcode codes, atomic subtypes, command union, class, field and priority types
package umi_pkg;

   localparam int CW = 32;                          // Command word width

   // Opcodes, bit 0 set for requests
   localparam logic [4:0] umi_invalid      = 5'h00;
   localparam logic [4:0] umi_req_read     = 5'h01; // Load
   localparam logic [4:0] umi_req_write    = 5'h03; // Store needing an ack
   localparam logic [4:0] umi_req_posted   = 5'h05; // Store without ack
   localparam logic [4:0] umi_req_rdma     = 5'h07;
   localparam logic [4:0] umi_req_atomic   = 5'h09;
   localparam logic [4:0] umi_req_user0    = 5'h0b;
   localparam logic [4:0] umi_req_future0  = 5'h0d;
   localparam logic [4:0] umi_req_error    = 5'h0f;
   localparam logic [4:0] umi_req_link     = 5'h1f;

   // Responses, bit 0 clear and nonzero
   localparam logic [4:0] umi_resp_read    = 5'h02;
   localparam logic [4:0] umi_resp_write   = 5'h04;
   localparam logic [4:0] umi_resp_user0   = 5'h06;
   localparam logic [4:0] umi_resp_user1   = 5'h08;
   localparam logic [4:0] umi_resp_future0 = 5'h0a;
   localparam logic [4:0] umi_resp_future1 = 5'h0c;
   localparam logic [4:0] umi_resp_link    = 5'h0e;

   // Atomic subtypes, carried in len
   localparam logic [7:0] umi_atomic_add   = 8'h00;
   localparam logic [7:0] umi_atomic_and   = 8'h01;
   localparam logic [7:0] umi_atomic_or    = 8'h02;
   localparam logic [7:0] umi_atomic_xor   = 8'h03;
   localparam logic [7:0] umi_atomic_max   = 8'h04;
   localparam logic [7:0] umi_atomic_min   = 8'h05;
   localparam logic [7:0] umi_atomic_maxu  = 8'h06;
   localparam logic [7:0] umi_atomic_minu  = 8'h07;
   localparam logic [7:0] umi_atomic_swap  = 8'h08;
   localparam logic [3:0] umi_atomic_none  = 4'hf; // Unknown or not atomic

   // Transaction layout of the command word
   typedef struct packed {
      logic [4:0] hostid;                           // [31:27]
      logic [1:0] ureq;                             // [26:25]
      logic       ex;                               // [24]
      logic       eof;                              // [23]
      logic       eom;                              // [22]
      logic [1:0] prot;                             // [21:20]
      logic [3:0] qos;                              // [19:16]
      logic [7:0] len;                              // [15:8]
      logic [2:0] size;                             // [7:5]
      logic [4:0] opcode;                           // [4:0]
   } umi_txn_t;

   // Control layout for link and error words
   typedef struct packed {
      logic [4:0]      hostid;                      // [31:27]
      logic [CW-14:0]  payload;                     // Everything between size and hostid
      logic [2:0]      size;                        // [7:5]
      logic [4:0]      opcode;                      // [4:0]
   } umi_ctrl_t;

   typedef union packed {
      umi_txn_t  txn;
      umi_ctrl_t ctrl;
   } umi_cmd_u;

   // One-hot style opcode flags plus atomic subtype
   typedef struct packed {
      logic       invalid;
      logic       request;
      logic       response;
      logic       read;
      logic       write;
      logic       posted;
      logic       rdma;
      logic       atomic;
      logic       user0;
      logic       future0;
      logic       error;
      logic       link;
      logic       read_resp;
      logic       write_resp;
      logic       user0_resp;
      logic       user1_resp;
      logic       future0_resp;
      logic       future1_resp;
      logic       link_resp;
      logic [3:0] atomic_op;                        // Subtype code or 15
   } umi_cmd_class_t;

   typedef struct packed {
      logic [4:0]  opcode;
      logic [2:0]  size;
      logic [7:0]  len;
      logic [3:0]  qos;
      logic [1:0]  prot;
      logic        eom;
      logic        eof;
      logic        ex;
      logic [18:0] user;                            // Assembled per command type
      logic [1:0]  err;                             // Response or error code
      logic [4:0]  hostid;
   } umi_cmd_fields_t;

   typedef enum logic {
      PRIO_LOW  = 1'b0,
      PRIO_HIGH = 1'b1
   } umi_prio_e;

endpackage

// File: source/umi_decode.sv
// Module umi_decode: combinational opcode classifier and atomic subtype decoder
`timescale 1ns/100ps

module umi_decode (
   input  umi_pkg::umi_cmd_u       cmd,
   output umi_pkg::umi_cmd_class_t cmd_class
);

   import umi_pkg::*;

   logic [4:0] op;                                  // Opcode shortcut
   logic [7:0] sub;                                 // Atomic subtype from len

   assign op  = cmd.txn.opcode;
   assign sub = cmd.txn.len;

   always_comb begin
      cmd_class           = '0;
      cmd_class.atomic_op = umi_atomic_none;        // Default when not atomic

      // Opcode match
      case (op)
         umi_req_read: begin
            cmd_class.read = 1'b1;
         end
         umi_req_write: begin
            cmd_class.write = 1'b1;                 // Acked store
         end
         umi_req_posted: begin
            cmd_class.posted = 1'b1;
         end
         umi_req_rdma: begin
            cmd_class.rdma = 1'b1;
         end
         umi_req_atomic: begin
            cmd_class.atomic = 1'b1;
         end
         umi_req_user0: begin
            cmd_class.user0 = 1'b1;
         end
         umi_req_future0: begin
            cmd_class.future0 = 1'b1;
         end
         umi_req_error: begin
            cmd_class.error = 1'b1;
         end
         umi_req_link: begin
            cmd_class.link = 1'b1;
         end
         umi_resp_read: begin
            cmd_class.read_resp = 1'b1;
         end
         umi_resp_write: begin
            cmd_class.write_resp = 1'b1;            // Write ack
         end
         umi_resp_user0: begin
            cmd_class.user0_resp = 1'b1;
         end
         umi_resp_user1: begin
            cmd_class.user1_resp = 1'b1;
         end
         umi_resp_future0: begin
            cmd_class.future0_resp = 1'b1;
         end
         umi_resp_future1: begin
            cmd_class.future1_resp = 1'b1;
         end
         umi_resp_link: begin
            cmd_class.link_resp = 1'b1;
         end
         umi_invalid: begin
            cmd_class.invalid = 1'b1;               // All-zero opcode
         end
         default: begin
            cmd_class.invalid = 1'b1;               // Unlisted code
         end
      endcase

      // Direction only for listed codes
      cmd_class.request  = ~cmd_class.invalid & op[0];
      cmd_class.response = ~cmd_class.invalid & ~op[0];

      // Subtype only meaningful for atomics
      if (cmd_class.atomic) begin
         case (sub)
            umi_atomic_add,
            umi_atomic_and,
            umi_atomic_or,
            umi_atomic_xor,
            umi_atomic_max,
            umi_atomic_min,
            umi_atomic_maxu,
            umi_atomic_minu,
            umi_atomic_swap: begin
               cmd_class.atomic_op = sub[3:0];      // Codes fit in 4 bits
            end
            default: begin
               cmd_class.atomic_op = umi_atomic_none;
            end
         endcase
      end
   end

endmodule

// File: source/umi_unpack.sv
// Module umi_unpack: combinational slicer of command word into raw fields, user field and error code
`timescale 1ns/100ps

module umi_unpack (
   input  umi_pkg::umi_cmd_u        cmd,
   input  umi_pkg::umi_cmd_class_t  cmd_class,
   output umi_pkg::umi_cmd_fields_t fields
);

   logic [18:0] user_c;                             // Assembled user field
   logic [1:0]  err_c;                              // Error code

   // User field depends on the word layout
   always_comb begin
      if (cmd_class.link) begin
         user_c = cmd.ctrl.payload;                 // Full ctrl payload
      end else if (cmd_class.link_resp) begin
         user_c = {2'b00, cmd.ctrl.payload[16:0]};  // Bits 24:8 only
      end else if (cmd_class.error) begin
         user_c = {8'h00,
                   cmd.txn.ex,
                   cmd.txn.eof,
                   cmd.txn.eom,
                   cmd.txn.len};                    // Bits 24:22 then len
      end else if (cmd_class.request) begin
         user_c = {17'h0_0000, cmd.txn.ureq};
      end else begin
         user_c = 19'h0_0000;                       // Plain responses carry none
      end
   end

   // Error code only for responses and errors
   assign err_c = (cmd_class.response | cmd_class.error) ? cmd.txn.ureq : 2'b00;

   // Raw slices, qualified later
   assign fields.opcode = cmd.txn.opcode;
   assign fields.size   = cmd.txn.size;
   assign fields.len    = cmd.txn.len;
   assign fields.qos    = cmd.txn.qos;
   assign fields.prot   = cmd.txn.prot;
   assign fields.eom    = cmd.txn.eom;
   assign fields.eof    = cmd.txn.eof;
   assign fields.ex     = cmd.txn.ex;
   assign fields.user   = user_c;
   assign fields.err    = err_c;
   assign fields.hostid = cmd.txn.hostid;

endmodule

// File: source/umi_cmd_merge.sv
// Module umi_cmd_merge: per-type field qualification, priority class and output register
`timescale 1ns/100ps

module umi_cmd_merge (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cmd_valid,
   input  umi_pkg::umi_cmd_class_t  cmd_class,
   input  umi_pkg::umi_cmd_fields_t raw_fields,
   output logic                     out_valid,
   output umi_pkg::umi_cmd_class_t  out_class,
   output umi_pkg::umi_cmd_fields_t out_fields,
   output umi_pkg::umi_prio_e       out_prio
);

   import umi_pkg::*;

   umi_cmd_fields_t qual_c;                         // Qualified fields
   umi_prio_e       prio_c;                         // Next priority
   logic            no_size;
   logic            no_len;
   logic            no_qos;                         // Also covers prot
   logic            no_tail;                        // Covers eof and ex

   // Which fields a command type ignores
   assign no_size = cmd_class.error | cmd_class.link | cmd_class.link_resp;
   assign no_len  = cmd_class.atomic | no_size;     // Atomics use len as subtype
   assign no_qos  = cmd_class.link | cmd_class.link_resp;
   assign no_tail = cmd_class.error | cmd_class.response;

   always_comb begin
      qual_c        = '0;
      qual_c.opcode = raw_fields.opcode;            // Always kept
      qual_c.hostid = raw_fields.hostid;            // Always kept
      if (!cmd_class.invalid) begin
         qual_c.size = no_size ? 3'b000 : raw_fields.size;
         qual_c.len  = no_len  ? 8'h00  : raw_fields.len;
         qual_c.qos  = no_qos  ? 4'h0   : raw_fields.qos;
         qual_c.prot = no_qos  ? 2'b00  : raw_fields.prot;
         qual_c.eom  = raw_fields.eom;
         qual_c.eof  = no_tail ? 1'b0   : raw_fields.eof;
         qual_c.ex   = no_tail ? 1'b0   : raw_fields.ex;
         qual_c.user = raw_fields.user;
         qual_c.err  = raw_fields.err;
      end
   end

   // Posted stores and every response go first
   assign prio_c = (cmd_class.posted | cmd_class.response) ? PRIO_HIGH : PRIO_LOW;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid  <= 1'b0;
         out_class  <= '0;
         out_fields <= '0;
         out_prio   <= PRIO_LOW;
      end else begin
         out_valid <= cmd_valid;                    // One-cycle strobe
         if (cmd_valid) begin
            out_class  <= cmd_class;
            out_fields <= qual_c;
            out_prio   <= prio_c;
         end                                        // Else hold last result
      end
   end

endmodule

// File: source/umi_cmd_parser.sv
// Module umi_cmd_parser: top level joining decoder, unpacker and merge register
`timescale 1ns/100ps

module umi_cmd_parser (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     cmd_valid,
   input  umi_pkg::umi_cmd_u        cmd,
   output logic                     out_valid,
   output umi_pkg::umi_cmd_class_t  out_class,
   output umi_pkg::umi_cmd_fields_t out_fields,
   output umi_pkg::umi_prio_e       out_prio
);

   import umi_pkg::*;

   umi_cmd_class_t  class_c;                        // Opcode class, combinational
   umi_cmd_fields_t raw_c;                          // Unqualified fields

   umi_decode decode_i (
      .cmd       (cmd),
      .cmd_class (class_c)
   );

   umi_unpack unpack_i (
      .cmd       (cmd),
      .cmd_class (class_c),
      .fields    (raw_c)
   );

   // Only registered stage
   umi_cmd_merge merge_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd_class  (class_c),
      .raw_fields (raw_c),
      .out_valid  (out_valid),
      .out_class  (out_class),
      .out_fields (out_fields),
      .out_prio   (out_prio)
   );

endmodule

// File: dv/umi_cmd_parser_sva.sv
// Assertion module umi_cmd_parser_sva for strobe timing, reset state and field qualification, plus its bind
`timescale 1ns/100ps

module umi_cmd_parser_sva (
   input logic                     clk,
   input logic                     rst_n,
   input logic                     cmd_valid,
   input logic                     out_valid,
   input umi_pkg::umi_cmd_class_t  out_class,
   input umi_pkg::umi_cmd_fields_t out_fields
);

   // Output strobe one cycle after the input strobe
   a_valid_rise: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid |=> out_valid)
      else $error("out_valid missing one cycle after cmd_valid");

   a_valid_fall: assert property (@(posedge clk) disable iff (!rst_n)
      !cmd_valid |=> !out_valid)
      else $error("out_valid high without a preceding cmd_valid");

   a_reset_clear: assert property (@(posedge clk)
      !rst_n |=> !out_valid && out_class == '0 && out_fields == '0)
      else $error("outputs not cleared by reset");

   // Atomics carry the subtype in len
   a_len_zero: assert property (@(posedge clk) disable iff (!rst_n)
      (out_class.atomic || out_class.error || out_class.link) |-> out_fields.len == 8'h00)
      else $error("len not zero for atomic, error or link");

   a_resp_tail: assert property (@(posedge clk) disable iff (!rst_n)
      out_class.response |-> !out_fields.eof && !out_fields.ex)
      else $error("eof or ex set on a response");

endmodule

bind umi_cmd_merge umi_cmd_parser_sva sva_i (
   .clk        (clk),
   .rst_n      (rst_n),
   .cmd_valid  (cmd_valid),
   .out_valid  (out_valid),
   .out_class  (out_class),
   .out_fields (out_fields)
);

// File: dv/umi_cmd_parser_tb.sv
// Testbench with stim file reader, command driver, output monitor, compare tasks and watchdog
`timescale 1ns/100ps

module umi_cmd_parser_tb;

   import umi_pkg::*;

   localparam int clk_half   = 4;                   // 8 ns period
   localparam int rst_cycles = 4;
   localparam int gap_every  = 4;                   // Idle gap after every fourth command
   localparam int gap_cycles = 2;
   localparam int margin     = 20;                  // Spare cycles on top of the run
   localparam logic [31:0] rst_cmd = 32'hffff_ffee; // Link response strobed while in reset

   logic            clk;
   logic            rst_n;
   logic            cmd_valid;
   umi_cmd_u        cmd;
   logic            out_valid;
   umi_cmd_class_t  out_class;
   umi_cmd_fields_t out_fields;
   umi_prio_e       out_prio;

   // One entry per stim line
   string           name_q[$];
   umi_cmd_u        cmd_q[$];
   umi_cmd_class_t  class_q[$];
   umi_cmd_fields_t fields_q[$];
   umi_prio_e       prio_q[$];

   int class_errs  = 0;
   int field_errs  = 0;
   int prio_errs   = 0;
   int valid_errs  = 0;
   int stim_errs   = 0;
   int cur_idx     = 0;                             // Index of the command on cmd
   bit loaded      = 1'b0;                          // Starts the watchdog

   umi_cmd_parser dut_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .out_valid  (out_valid),
      .out_class  (out_class),
      .out_fields (out_fields),
      .out_prio   (out_prio)
   );

   initial begin
      clk = 1'b0;
      forever #clk_half clk = ~clk;
   end

   task automatic load_stim(output int count);
      int          fd;
      int          nread;
      string       line;
      string       tname;
      logic [31:0] w_cmd;
      logic [63:0] w_class;
      logic [63:0] w_fields;
      logic [3:0]  w_prio;
      count = 0;
      fd = $fopen("dv/umi_cmd_stim.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open dv/umi_cmd_stim.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
            nread = $sscanf(line, "%s %h %h %h %h", tname, w_cmd, w_class, w_fields, w_prio);
            if (nread != 5) begin
               stim_errs++;
               $display("ERROR: malformed stim line %s", line);
            end else begin
               name_q.push_back(tname);
               cmd_q.push_back(umi_cmd_u'(w_cmd));
               class_q.push_back(umi_cmd_class_t'(w_class[$bits(umi_cmd_class_t)-1:0]));
               fields_q.push_back(umi_cmd_fields_t'(w_fields[$bits(umi_cmd_fields_t)-1:0]));
               prio_q.push_back(umi_prio_e'(w_prio[0]));
               count++;
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic check_valid(input string tname, input logic exp, input logic act);
      if (act !== exp) begin
         valid_errs++;
         $display("[ERROR] %s out_valid expected %b actual %b", tname, exp, act);
      end
   endtask

   task automatic check_class(input string tname, input umi_cmd_class_t exp,
                              input umi_cmd_class_t act);
      if (act !== exp) begin
         class_errs++;
         $display("[ERROR] %s class expected %h actual %h", tname, exp, act);
      end
   endtask

   task automatic check_fields(input string tname, input umi_cmd_fields_t exp,
                               input umi_cmd_fields_t act);
      if (act !== exp) begin
         field_errs++;
         $display("[ERROR] %s fields expected %h actual %h", tname, exp, act);
      end
   endtask

   task automatic check_prio(input string tname, input umi_prio_e exp, input umi_prio_e act);
      if (act !== exp) begin
         prio_errs++;
         $display("[ERROR] %s prio expected %b actual %b", tname, exp, act);
      end
   endtask

   // Samples at falling edges one cycle behind the drive
   initial begin : monitor
      bit    prev_valid;
      int    prev_idx;
      int    last_idx;
      string tname;
      prev_valid = 1'b0;
      prev_idx   = 0;
      last_idx   = -1;                              // Nothing captured yet
      @(posedge clk);
      forever begin
         @(negedge clk);
         if (prev_valid) begin
            last_idx = prev_idx;
         end
         if (last_idx < 0) begin
            tname = "reset";
         end else begin
            tname = prev_valid ? name_q[last_idx] : {name_q[last_idx], "_hold"};
         end
         check_valid(tname, prev_valid, out_valid);
         if (last_idx < 0) begin
            check_class(tname, '0, out_class);      // Reset state
            check_fields(tname, '0, out_fields);
            check_prio(tname, PRIO_LOW, out_prio);
         end else begin
            check_class(tname, class_q[last_idx], out_class);
            check_fields(tname, fields_q[last_idx], out_fields);
            check_prio(tname, prio_q[last_idx], out_prio);
         end
         prev_valid = cmd_valid & rst_n;            // What the next edge captures
         prev_idx   = cur_idx;
      end
   end

   initial begin : main
      int n;
      int total;
      rst_n     = 1'b0;
      cmd_valid = 1'b1;                             // Strobe held during reset
      cmd       = umi_cmd_u'(rst_cmd);
      load_stim(n);
      if (n <= 0) begin
         $display("ERROR: no commands loaded from the stim file");
         $display("** FAIL **");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (rst_cycles - 1) @(posedge clk);
         cmd_valid <= 1'b0;                         // Quiet for the last reset edge
         @(posedge clk);
         rst_n <= 1'b1;
         for (int i = 0; i < n; i++) begin
            @(posedge clk);
            cmd_valid <= 1'b1;
            cmd       <= cmd_q[i];
            cur_idx   <= i;
            if (i % gap_every == gap_every - 1) begin
               @(posedge clk);
               cmd_valid <= 1'b0;                   // Idle cycles between bursts
               repeat (gap_cycles - 1) @(posedge clk);
            end
         end
         @(posedge clk);
         cmd_valid <= 1'b0;
         repeat (3) @(posedge clk);
         @(negedge clk);
         #1;
         total = class_errs + field_errs + prio_errs + valid_errs + stim_errs;
         $display("Errors class %0d fields %0d prio %0d valid %0d stim %0d (%0d commands)",
                  class_errs, field_errs, prio_errs, valid_errs, stim_errs, n);
         if (total == 0) begin
            $display("** PASS **");
         end else begin
            $display("** FAIL **");
         end
         $finish;
      end
   end

   // Four cycles per command is well above the worst gap pattern
   initial begin : watchdog
      int limit;
      wait (loaded);
      limit = (name_q.size() * 4 + rst_cycles + margin) * 2 * clk_half;
      #(limit);
      $display("ERROR: run timed out after %0d ns without finishing the commands", limit);
      $display("** FAIL **");
      $finish;
   end

endmodule

// File: dv/umi_cmd_stim.txt
# Columns: test name, command word, expected class word (23 bits), expected fields word (51 bits), expected priority (0 low, 1 high)
# All values in hex, one command per line
# Requests with every field populated
req_read         adea3ca1 28000f 069e55c000115 0
req_write        adea3ca3 24000f 0e9e55c000115 0
req_posted       adea3ca5 22000f 169e55c000115 1
req_rdma         adea3ca7 21000f 1e9e55c000115 0
req_user0        adea3cab 20400f 2e9e55c000115 0
req_future0      adea3cad 20200f 369e55c000115 0
req_read_b       5215c341 28000f 0561aa000008a 0
req_write_b      5215c343 24000f 0d61aa000008a 0
req_posted_b     5215c345 22000f 1561aa000008a 1
req_read_min     00000001 28000f 0400000000000 0
# Responses drop eof and ex, carry err
resp_read        adea3ca2 10040f 0a9e550000055 1
resp_write       adea3ca4 10020f 129e550000055 1
resp_user0       adea3ca6 10010f 1a9e550000055 1
resp_user1       adea3ca8 10008f 229e550000055 1
resp_future0     adea3caa 10004f 2a9e550000055 1
resp_future1     adea3cac 10002f 329e550000055 1
resp_read_b      5215c342 10040f 0961aa000002a 1
# Link, link response and error words
link_a           adea3cbf 20080f 7c0001ef51e15 0
link_b           5215c35f 20080f 7c000010ae18a 0
link_resp_a      adea3cae 10001f 3800010f51e55 1
link_resp_b      5215c34e 10001f 38000000ae1aa 1
error_a          adea3caf 20100f 3c00550039e55 0
error_b          5215c34f 20100f 3c002a00061aa 0
# Atomic subtypes from len
atomic_add       adea00a9 208000 268055c000115 0
atomic_and       adea01a9 208001 268055c000115 0
atomic_or        adea02a9 208002 268055c000115 0
atomic_xor       adea03a9 208003 268055c000115 0
atomic_max       adea04a9 208004 268055c000115 0
atomic_min       adea05a9 208005 268055c000115 0
atomic_maxu      adea06a9 208006 268055c000115 0
atomic_minu      adea07a9 208007 268055c000115 0
atomic_swap      adea08a9 208008 268055c000115 0
atomic_unk09     adea09a9 20800f 268055c000115 0
atomic_unk10     adea10a9 20800f 268055c000115 0
atomic_unkff     adeaffa9 20800f 268055c000115 0
atomic_unk_b     5215c349 20800f 25002a000008a 0
# Unlisted opcodes keep only opcode and hostid
inv_00           adea3ca0 40000f 0000000000015 0
inv_10           adea3cb0 40000f 4000000000015 0
inv_13           adea3cb3 40000f 4c00000000015 0
inv_1e           adea3cbe 40000f 7800000000015 0
inv_11_b         5215c351 40000f 440000000000a 0
inv_zero         00000000 40000f 0000000000000 0

// File: build.f
source/umi_pkg.sv
source/umi_decode.sv
source/umi_unpack.sv
source/umi_cmd_merge.sv
source/umi_cmd_parser.sv
dv/umi_cmd_parser_sva.sv
dv/umi_cmd_parser_tb.sv

// File: Bender.yml
package:
  name: umi_cmd_parser

dependencies: {}

sources:
  # Design, package first
  - files:
      - source/umi_pkg.sv
      - source/umi_decode.sv
      - source/umi_unpack.sv
      - source/umi_cmd_merge.sv
      - source/umi_cmd_parser.sv

  # Verification only
  - target: test
    files:
      - dv/umi_cmd_parser_sva.sv
      - dv/umi_cmd_parser_tb.sv
